// ==== Makefile ====
# Verilator build and run for the digital clock testbench

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -f flist.f --top-module tb_digital_clock \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only -Wall hdl/clock_pkg.sv hdl/disp_pkg.sv hdl/ctrl_if.sv \
		hdl/tick_gen.sv hdl/button_sync.sv hdl/mode_ctrl.sv hdl/hms_counter.sv \
		hdl/alarm_unit.sv hdl/digit_scan.sv hdl/digital_clock.sv \
		--top-module digital_clock

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_digital_clock.sv ====
`timescale 1ns/1ps

module tb_digital_clock;

	import clock_pkg::*;
	import disp_pkg::*;

	localparam int TICK_DIV = 64;
	localparam int SCAN_DIV = 4;

	// --------------------
	// step table types
	// --------------------

	typedef enum {ACT_MODE, ACT_POS, ACT_INC, ACT_ALARM, ACT_WAIT, ACT_UNTIL} act_e;
	typedef enum {CHK_NONE, CHK_EXACT, CHK_RANGE, CHK_ALARM} chk_e;

	typedef struct {
		act_e act;
		// presses, or seconds for wait and until
		int   arg;
		chk_e chk;
		hms_t exp;
		// extra seconds allowed above exp in a range check
		int   slack;
		logic alarm;
	} step_t;

	// reference segment codes, a..g from msb
	localparam seg_t DIGIT_SEGS [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;
	seg_t       o_seg;
	digit_enb_t o_seg_enb;
	logic       o_alarm;

	step_t steps [$];
	int    errors;
	int    checks;
	int    cycles;
	int    limit;

	digital_clock #(
		.TICK_DIV (TICK_DIV),
		.SCAN_DIV (SCAN_DIV)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_sw0     (btn[0]),
		.i_sw1     (btn[1]),
		.i_sw2     (btn[2]),
		.i_sw3     (btn[3]),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: run went past %0d cycles", limit);
			$display("Done: errors found");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------

	function automatic hms_t make_hms(int h, int m, int s);
		hms_t t;
		t.hou = 6'(h);
		t.min = 6'(m);
		t.sec = 6'(s);
		return t;
	endfunction

	function automatic int to_secs(hms_t t);
		return int'(t.hou) * 3600 + int'(t.min) * 60 + int'(t.sec);
	endfunction

	// segment pattern back to a digit, -1 if unknown
	function automatic int decode_seg(seg_t s);
		for (int i = 0; i < 10; i++) begin
			if (s == DIGIT_SEGS[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic add_step(act_e act, int arg, chk_e chk, hms_t exp, int slack, logic alarm);
		step_t s;
		s.act   = act;
		s.arg   = arg;
		s.chk   = chk;
		s.exp   = exp;
		s.slack = slack;
		s.alarm = alarm;
		steps.push_back(s);
	endtask

	// 3 high, 3 low
	task automatic press_button(int idx);
		@(posedge clk);
		btn[idx] <= 1'b1;
		repeat (3) @(posedge clk);
		btn[idx] <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// one pass over the six digits, in scan order
	task automatic read_display(output hms_t t, output bit ok);
		int d [6];
		int waited;
		ok = 1'b1;
		t  = '0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			waited = 0;
			@(negedge clk);
			while (o_seg_enb !== ~(digit_enb_t'(1) << i) && waited < 40) begin
				@(negedge clk);
				waited++;
			end
			if (waited >= 40) begin
				$display("digit enable %0d never came up", i);
				errors++;
				ok = 1'b0;
				return;
			end
			d[i] = decode_seg(o_seg);
			if (d[i] < 0) begin
				$display("unknown segment code %b on digit %0d", o_seg, i);
				errors++;
				ok = 1'b0;
				return;
			end
		end
		t.sec = 6'(d[1] * 10 + d[0]);
		t.min = 6'(d[3] * 10 + d[2]);
		t.hou = 6'(d[5] * 10 + d[4]);
	endtask

	// two matching passes, guards against a tick mid read
	task automatic read_stable(output hms_t t, output bit ok);
		hms_t a;
		hms_t b;
		read_display(a, ok);
		for (int n = 0; n < 3 && ok; n++) begin
			read_display(b, ok);
			if (ok && a == b) begin
				t = a;
				return;
			end
			a = b;
		end
		if (ok) begin
			$display("display never settled on one time");
			errors++;
			ok = 1'b0;
		end
		t = a;
	endtask

	// --------------------
	// compare tasks
	// --------------------

	task automatic check_time(hms_t exp, hms_t act);
		checks++;
		if (act !== exp) begin
			$display("ERROR display time: expected %h actual %h", exp, act);
			errors++;
		end
	endtask

	task automatic check_time_range(hms_t lo, int slack, hms_t act);
		checks++;
		if (to_secs(act) < to_secs(lo) || to_secs(act) > to_secs(lo) + slack) begin
			$display("ERROR display time: expected %h + %0h s actual %h", lo, slack, act);
			errors++;
		end
	endtask

	task automatic check_alarm(logic exp);
		@(negedge clk);
		checks++;
		if (o_alarm !== exp) begin
			$display("ERROR o_alarm: expected %h actual %h", exp, o_alarm);
			errors++;
		end
	endtask

	task automatic check_seg(seg_t exp);
		checks++;
		if (o_seg !== exp) begin
			$display("ERROR o_seg: expected %h actual %h", exp, o_seg);
			errors++;
		end
	endtask

	task automatic check_enb(digit_enb_t exp);
		checks++;
		if (o_seg_enb !== exp) begin
			$display("ERROR o_seg_enb: expected %h actual %h", exp, o_seg_enb);
			errors++;
		end
	endtask

	// poll the display until it shows exp or the seconds run out
	task automatic wait_for_time(hms_t exp, int secs);
		hms_t t;
		bit   ok;
		int   start;
		start = cycles;
		t     = '1;
		while (t != exp && (cycles - start) < secs * TICK_DIV) begin
			read_display(t, ok);
		end
		checks++;
		if (t != exp) begin
			$display("display never reached %h, last read %h", exp, t);
			errors++;
		end
	endtask

	// --------------------
	// table
	// --------------------

	task automatic load_table();
		// setup, fields step with no carry
		add_step(ACT_MODE,   1, CHK_EXACT, make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_INC,   59, CHK_EXACT, make_hms(0, 0, 59),   0, 1'b0);
		add_step(ACT_POS,    1, CHK_NONE,  make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_INC,   59, CHK_EXACT, make_hms(0, 59, 59),  0, 1'b0);
		add_step(ACT_POS,    1, CHK_NONE,  make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_INC,   23, CHK_EXACT, make_hms(23, 59, 59), 0, 1'b0);
		add_step(ACT_POS,    1, CHK_NONE,  make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_INC,    1, CHK_EXACT, make_hms(23, 59, 0),  0, 1'b0);
		// seconds stepped back round to 59
		add_step(ACT_INC,   59, CHK_EXACT, make_hms(23, 59, 59), 0, 1'b0);
		// frozen while in setup
		add_step(ACT_WAIT,   2, CHK_EXACT, make_hms(23, 59, 59), 0, 1'b0);
		// back to clock, full carry and hour wrap
		add_step(ACT_MODE,   2, CHK_NONE,  make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_UNTIL,  4, CHK_ALARM, make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_WAIT,   3, CHK_RANGE, make_hms(0, 0, 3),    2, 1'b0);
		// alarm mode shows the alarm time
		add_step(ACT_MODE,   2, CHK_EXACT, make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_POS,    1, CHK_NONE,  make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_INC,    1, CHK_EXACT, make_hms(0, 1, 0),    0, 1'b0);
		add_step(ACT_MODE,   1, CHK_RANGE, make_hms(0, 0, 4),    6, 1'b0);
		// enable, match, latch, disable
		add_step(ACT_ALARM,  1, CHK_ALARM, make_hms(0, 0, 0),    0, 1'b0);
		add_step(ACT_UNTIL, 70, CHK_ALARM, make_hms(0, 1, 0),    0, 1'b1);
		add_step(ACT_WAIT,   2, CHK_RANGE, make_hms(0, 1, 2),    2, 1'b1);
		add_step(ACT_ALARM,  1, CHK_ALARM, make_hms(0, 0, 0),    0, 1'b0);
	endtask

	// presses x6, seconds x64, reads x30, doubled
	function automatic int run_limit();
		int presses;
		int secs;
		int reads;
		presses = 0;
		secs    = 2;
		reads   = 4;
		foreach (steps[i]) begin
			if (steps[i].act == ACT_WAIT || steps[i].act == ACT_UNTIL) begin
				secs += steps[i].arg;
			end else begin
				presses += steps[i].arg;
			end
			if (steps[i].chk == CHK_EXACT || steps[i].chk == CHK_RANGE) begin
				reads += 4;
			end
			reads++;
		end
		return 2 * (presses * 6 + secs * TICK_DIV + reads * 30);
	endfunction

	// --------------------
	// main sequence
	// --------------------

	initial begin
		hms_t t;
		bit   ok;
		step_t s;
		rst_n  = 1'b0;
		btn    = 4'b0000;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit  = 0;
		load_table();
		limit = run_limit();

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// reset state, digit 0 showing a zero
		@(negedge clk);
		check_enb(~digit_enb_t'(1));
		check_seg(DIGIT_SEGS[0]);
		read_stable(t, ok);
		check_time(make_hms(0, 0, 0), t);
		check_alarm(1'b0);

		foreach (steps[i]) begin
			s = steps[i];
			case (s.act)
				ACT_MODE:  repeat (s.arg) press_button(BTN_MODE);
				ACT_POS:   repeat (s.arg) press_button(BTN_POS);
				ACT_INC:   repeat (s.arg) press_button(BTN_SET);
				ACT_ALARM: repeat (s.arg) press_button(BTN_ALARM);
				ACT_WAIT:  repeat (s.arg * TICK_DIV) @(posedge clk);
				ACT_UNTIL: wait_for_time(s.exp, s.arg);
				default:   ;
			endcase
			// let the last press land
			repeat (4) @(posedge clk);
			case (s.chk)
				CHK_EXACT: begin
					read_stable(t, ok);
					check_time(s.exp, t);
					check_alarm(s.alarm);
				end
				CHK_RANGE: begin
					read_stable(t, ok);
					check_time_range(s.exp, s.slack, t);
					check_alarm(s.alarm);
				end
				CHK_ALARM: check_alarm(s.alarm);
				default:   ;
			endcase
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/clock_pkg.sv
hdl/disp_pkg.sv
hdl/ctrl_if.sv
hdl/tick_gen.sv
hdl/button_sync.sv
hdl/mode_ctrl.sv
hdl/hms_counter.sv
hdl/alarm_unit.sv
hdl/digit_scan.sv
hdl/digital_clock.sv
dv/tb_digital_clock.sv

// ==== hdl/alarm_unit.sv ====
`timescale 1ns/1ps

module alarm_unit (
	input  logic            clk,
	input  logic            rst_n,
	ctrl_if.alarm           i_ctrl,
	input  clock_pkg::hms_t i_time,
	output clock_pkg::hms_t o_alarm_time,
	output logic            o_alarm
);

	import clock_pkg::*;

	logic edit;
	logic match;

	// increments only land in alarm mode
	assign edit  = i_ctrl.set_pulse && (i_ctrl.mode == MODE_ALARM);

	// full hh:mm:ss compare
	assign match = (i_time == o_alarm_time);

	// --------------------
	// alarm time store
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_time <= '0;
		end else if (edit) begin
			// same no carry rule as setup
			o_alarm_time <= hms_inc_field(o_alarm_time, i_ctrl.position);
		end
	end

	// --------------------
	// alarm latch
	// stays up after the match second passes, until disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_ctrl.alarm_en) begin
			o_alarm <= 1'b0;
		end else if (match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

// ==== hdl/button_sync.sv ====
`timescale 1ns/1ps

module button_sync (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [clock_pkg::NUM_BUTTONS-1:0] i_btn,
	output logic [clock_pkg::NUM_BUTTONS-1:0] o_press
);

	import clock_pkg::*;

	// two sync stages, then a delayed copy for the edge
	logic [NUM_BUTTONS-1:0] meta;
	logic [NUM_BUTTONS-1:0] sync;
	logic [NUM_BUTTONS-1:0] sync_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			meta    <= '0;
			sync    <= '0;
			sync_d  <= '0;
			o_press <= '0;
		end else begin
			meta    <= i_btn;
			sync    <= meta;
			sync_d  <= sync;
			// rising edge only, a held button gives one pulse
			o_press <= sync & ~sync_d;
		end
	end

endmodule

// ==== hdl/clock_pkg.sv ====
package clock_pkg;

	// --------------------
	// time fields
	// --------------------

	// one field, 0 to 59
	typedef logic [5:0] hms_field_t;

	typedef struct packed {
		hms_field_t hou;
		hms_field_t min;
		hms_field_t sec;
	} hms_t;

	// last legal value per field
	localparam hms_field_t MAX_SEC = 6'd59;
	localparam hms_field_t MAX_MIN = 6'd59;
	localparam hms_field_t MAX_HOU = 6'd23;

	// --------------------
	// modes, positions
	// --------------------

	// mode button cycles clock -> setup -> alarm
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	// position button cycles sec -> min -> hou
	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_t;

	// clocks per second, clocks per digit
	localparam int TICK_DIV_DEFAULT = 50_000_000;
	localparam int SCAN_DIV_DEFAULT = 50_000;

	// button roles, index into the press vector
	localparam int NUM_BUTTONS = 4;
	localparam int BTN_MODE    = 0;
	localparam int BTN_POS     = 1;
	localparam int BTN_SET     = 2;
	localparam int BTN_ALARM   = 3;

	// step one field, back to 0 past its limit
	function automatic hms_field_t field_inc(hms_field_t f, hms_field_t lim);
		return (f >= lim) ? 6'd0 : f + 6'd1;
	endfunction

	// setup style increment, selected field only, no carry
	function automatic hms_t hms_inc_field(hms_t t, pos_t p);
		hms_t r;
		r = t;
		case (p)
			POS_SEC: r.sec = field_inc(t.sec, MAX_SEC);
			POS_MIN: r.min = field_inc(t.min, MAX_MIN);
			POS_HOU: r.hou = field_inc(t.hou, MAX_HOU);
			default: r = t;
		endcase
		return r;
	endfunction

endpackage

// ==== hdl/ctrl_if.sv ====
`timescale 1ns/1ps

// user control state, shared by the time keepers and the display
interface ctrl_if;

	import clock_pkg::*;

	mode_t mode;
	pos_t  position;
	// one cycle increment request
	logic  set_pulse;
	logic  alarm_en;

	modport ctrl  (output mode, output position, output set_pulse, output alarm_en);
	// running time ignores alarm enable
	modport keep  (input mode, input position, input set_pulse);
	modport alarm (input mode, input position, input set_pulse, input alarm_en);
	// display only picks the source
	modport disp  (input mode);

endinterface

// ==== hdl/digit_scan.sv ====
`timescale 1ns/1ps

module digit_scan (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_scan,
	ctrl_if.disp                 i_ctrl,
	input  clock_pkg::hms_t      i_time,
	input  clock_pkg::hms_t      i_alarm_time,
	output disp_pkg::seg_t       o_seg,
	output disp_pkg::digit_enb_t o_seg_enb
);

	import clock_pkg::*;
	import disp_pkg::*;

	hms_t       shown;
	digit_t     digits [NUM_DIGITS];
	digit_idx_t idx;
	digit_idx_t idx_next;
	digit_t     digit_next;

	// alarm mode shows the alarm time
	assign shown = (i_ctrl.mode == MODE_ALARM) ? i_alarm_time : i_time;

	// --------------------
	// tens / ones split
	// index 0 is seconds ones
	assign digits[0] = digit_t'(shown.sec % 10);
	assign digits[1] = digit_t'(shown.sec / 10);
	assign digits[2] = digit_t'(shown.min % 10);
	assign digits[3] = digit_t'(shown.min / 10);
	assign digits[4] = digit_t'(shown.hou % 10);
	assign digits[5] = digit_t'(shown.hou / 10);

	// next digit, 5 wraps to 0
	assign idx_next   = (idx == digit_idx_t'(NUM_DIGITS - 1)) ? 3'd0 : idx + 3'd1;
	assign digit_next = digits[idx_next];

	// --------------------
	// registered outputs
	// segments and enable move together on the scan pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			o_seg     <= SEG_CODE[0];
			o_seg_enb <= ~digit_enb_t'(1);
		end else if (i_scan) begin
			idx       <= idx_next;
			o_seg     <= (digit_next <= 4'd9) ? SEG_CODE[digit_next] : SEG_BLANK;
			// one low bit for the selected digit
			o_seg_enb <= ~(digit_enb_t'(1) << idx_next);
		end
	end

endmodule

// ==== hdl/digital_clock.sv ====
`timescale 1ns/1ps

module digital_clock #(
	parameter int TICK_DIV = clock_pkg::TICK_DIV_DEFAULT,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV_DEFAULT
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sw0,
	input  logic       i_sw1,
	input  logic       i_sw2,
	input  logic       i_sw3,
	output logic [6:0] o_seg,
	output logic [5:0] o_seg_enb,
	output logic       o_alarm
);

	import clock_pkg::*;

	logic                   sec_tick;
	logic                   scan_tick;
	logic [NUM_BUTTONS-1:0] btn;
	logic [NUM_BUTTONS-1:0] press;
	hms_t                   cur_time;
	hms_t                   alarm_time;

	ctrl_if u_ctrl_if ();

	// sw0 mode, sw1 field, sw2 increment, sw3 alarm enable
	assign btn = {i_sw3, i_sw2, i_sw1, i_sw0};

	// --------------------
	// enable pulses
	tick_gen #(
		.DIV (TICK_DIV)
	) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(
		.DIV (SCAN_DIV)
	) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// --------------------
	// buttons and control
	button_sync u_button_sync (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_btn   (btn),
		.o_press (press)
	);

	mode_ctrl u_mode_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_press (press),
		.o_ctrl  (u_ctrl_if)
	);

	// --------------------
	// time keeping
	hms_counter u_hms_counter (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (sec_tick),
		.i_ctrl (u_ctrl_if),
		.o_time (cur_time)
	);

	alarm_unit u_alarm_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_ctrl       (u_ctrl_if),
		.i_time       (cur_time),
		.o_alarm_time (alarm_time),
		.o_alarm      (o_alarm)
	);

	// display mux
	digit_scan u_digit_scan (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan       (scan_tick),
		.i_ctrl       (u_ctrl_if),
		.i_time       (cur_time),
		.i_alarm_time (alarm_time),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

// ==== hdl/disp_pkg.sv ====
package disp_pkg;

	// --------------------
	// display geometry
	// --------------------

	// hh:mm:ss, index 0 is seconds ones
	localparam int NUM_DIGITS = 6;

	// segments a..g from msb down, active high
	typedef logic [6:0] seg_t;

	// one bcd value
	typedef logic [3:0] digit_t;

	// 0 to 5
	typedef logic [2:0] digit_idx_t;

	// active low, one bit low at a time
	typedef logic [NUM_DIGITS-1:0] digit_enb_t;

	// --------------------
	// segment codes
	// --------------------

	// digits 0..9, zero lights everything but g
	localparam seg_t SEG_CODE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	// anything outside 0..9
	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

// ==== hdl/hms_counter.sv ====
`timescale 1ns/1ps

module hms_counter (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_tick,
	ctrl_if.keep            i_ctrl,
	output clock_pkg::hms_t o_time
);

	import clock_pkg::*;

	logic setup;
	logic sec_wrap;
	logic min_wrap;

	// time frozen while setting
	assign setup    = (i_ctrl.mode == MODE_SETUP);

	// carry conditions for the running chain
	assign sec_wrap = (o_time.sec == MAX_SEC);
	assign min_wrap = (o_time.min == MAX_MIN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (setup) begin
			// --------------------
			// setup, selected field only
			if (i_ctrl.set_pulse) begin
				o_time <= hms_inc_field(o_time, i_ctrl.position);
			end
		end else if (i_tick) begin
			// --------------------
			// running, sec -> min -> hou
			o_time.sec <= field_inc(o_time.sec, MAX_SEC);
			if (sec_wrap) begin
				o_time.min <= field_inc(o_time.min, MAX_MIN);
				if (min_wrap) begin
					// 23 wraps to 0
					o_time.hou <= field_inc(o_time.hou, MAX_HOU);
				end
			end
		end
	end

endmodule

// ==== hdl/mode_ctrl.sv ====
`timescale 1ns/1ps

module mode_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [clock_pkg::NUM_BUTTONS-1:0] i_press,
	ctrl_if.ctrl                              o_ctrl
);

	import clock_pkg::*;

	// increment goes straight through, the counters register it
	assign o_ctrl.set_pulse = i_press[BTN_SET];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_ctrl.mode     <= MODE_CLOCK;
			o_ctrl.position <= POS_SEC;
			o_ctrl.alarm_en <= 1'b0;
		end else begin
			// --------------------
			// mode, wraps after alarm
			if (i_press[BTN_MODE]) begin
				case (o_ctrl.mode)
					MODE_CLOCK: o_ctrl.mode <= MODE_SETUP;
					MODE_SETUP: o_ctrl.mode <= MODE_ALARM;
					default:    o_ctrl.mode <= MODE_CLOCK;
				endcase
			end
			// --------------------
			// field select, wraps after hours
			if (i_press[BTN_POS]) begin
				case (o_ctrl.position)
					POS_SEC: o_ctrl.position <= POS_MIN;
					POS_MIN: o_ctrl.position <= POS_HOU;
					default: o_ctrl.position <= POS_SEC;
				endcase
			end
			// alarm on/off
			if (i_press[BTN_ALARM]) begin
				o_ctrl.alarm_en <= ~o_ctrl.alarm_en;
			end
		end
	end

endmodule

// ==== hdl/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] cnt;

	// count 0..DIV-1, pulse once per wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CNT_W'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule
